// ==== include/mipsDecode_params.svh ====
// Widths and register-file sizing for the decode stage, included by the package and RTL
`ifndef MIPSDECODE_PARAMS_SVH
`define MIPSDECODE_PARAMS_SVH

// Register and PC width
`define DATA_W 32

// Register address width
`define REG_ADDR_W 5

// Number of architectural registers
`define REG_COUNT 32

// Register written by jal
`define LINK_REG 31

`endif

// ==== design/mipsDecodePkg.sv ====
// Operation and format enums plus the pipeline bundles shared by the decode stage modules
`include "mipsDecode_params.svh"

package mipsDecodePkg;

    // opNop must stay at zero so a cleared ID/EX register reads as a bubble
    typedef enum logic [5:0] {
        opNop = 6'd0,
        // R-type ALU
        opAdd, opSub, opAddu, opSubu, opAnd, opOr, opXor, opNor, opSlt, opSltu,
        // R-type shifts
        opSll, opSllv, opSrl, opSrlv, opSra, opSrav,
        // Register jumps
        opJr, opJalr,
        // I-type ALU
        opAddi, opAddiu, opAndi, opOri, opXori, opLui, opSlti, opSltiu,
        // Loads
        opLw, opLh, opLhu, opLb, opLbu,
        // Stores
        opSw, opSh, opSb,
        // Branches
        opBeq, opBne, opBlez, opBgtz, opBgez, opBltz,
        // Absolute jumps
        opJ, opJal
    } opCode_e;

    typedef enum logic [1:0] {
        fmtR,
        fmtI,
        fmtJ
    } instrFormat_e;

    // Decoder output, raw fields alongside the resolved operation
    typedef struct packed {
        opCode_e                op;
        instrFormat_e           format;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rd;
        logic [4:0]             shamt;
        logic [15:0]            imm16;
        logic [25:0]            jumpTarget;
    } decodedInstr_t;

    typedef struct packed {
        logic [`DATA_W-1:0]     instr;
        logic [`DATA_W-1:0]     pc;
    } fetchBundle_t;

    // Writeback port, en acts as a single-cycle strobe
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } regWrite_t;

    typedef struct packed {
        opCode_e                op;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     rsData;
        logic [`DATA_W-1:0]     rtData;
        logic [15:0]            imm16;
        logic [4:0]             shamt;
        logic [`REG_ADDR_W-1:0] destReg;
        logic [`DATA_W-1:0]     destData;
    } idExBundle_t;

    // Branch resolution for the next-PC logic
    typedef struct packed {
        opCode_e                op;
        logic                   taken;
    } branchInfo_t;

endpackage

// ==== design/instrDecoder.sv ====
// Combinational MIPS decoder that turns an instruction word into an operation, format and fields
`include "mipsDecode_params.svh"

module instrDecoder import mipsDecodePkg::*; (
    input  logic [`DATA_W-1:0] instr,
    output decodedInstr_t      dec
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Field split is fixed by the MIPS encoding
        dec.rs         = instr[25:21];
        dec.rt         = instr[20:16];
        dec.rd         = instr[15:11];
        dec.shamt      = instr[10:6];
        dec.imm16      = instr[15:0];
        dec.jumpTarget = instr[25:0];

        // Unknown encodings fall through as a bubble
        dec.op     = opNop;
        dec.format = fmtI;

        if (instr != '0) begin
            if (opcode == 6'b000000) begin
                // SPECIAL, selected by funct
                dec.format = fmtR;
                case (funct)
                    6'b100000: dec.op = opAdd;
                    6'b100010: dec.op = opSub;
                    6'b100001: dec.op = opAddu;
                    6'b100011: dec.op = opSubu;
                    6'b100100: dec.op = opAnd;
                    6'b100101: dec.op = opOr;
                    6'b100110: dec.op = opXor;
                    6'b100111: dec.op = opNor;
                    6'b101010: dec.op = opSlt;
                    6'b101011: dec.op = opSltu;
                    6'b000000: dec.op = opSll;
                    6'b000100: dec.op = opSllv;
                    6'b000010: dec.op = opSrl;
                    6'b000110: dec.op = opSrlv;
                    6'b000011: dec.op = opSra;
                    6'b000111: dec.op = opSrav;
                    6'b001000: dec.op = opJr;
                    6'b001001: dec.op = opJalr;
                    default: begin
                        dec.op     = opNop;
                        dec.format = fmtI;
                    end
                endcase
            end else if (opcode == 6'b000001) begin
                // REGIMM, rt picks the condition
                case (dec.rt)
                    5'b00001: dec.op = opBgez;
                    5'b00000: dec.op = opBltz;
                    default:  dec.op = opNop;
                endcase
            end else begin
                case (opcode)
                    // Immediate ALU
                    6'b001000: dec.op = opAddi;
                    6'b001001: dec.op = opAddiu;
                    6'b001100: dec.op = opAndi;
                    6'b001101: dec.op = opOri;
                    6'b001110: dec.op = opXori;
                    6'b001111: dec.op = opLui;
                    6'b001010: dec.op = opSlti;
                    6'b001011: dec.op = opSltiu;
                    // Loads
                    6'b100011: dec.op = opLw;
                    6'b100001: dec.op = opLh;
                    6'b100101: dec.op = opLhu;
                    6'b100000: dec.op = opLb;
                    6'b100100: dec.op = opLbu;
                    // Stores
                    6'b101011: dec.op = opSw;
                    6'b101001: dec.op = opSh;
                    6'b101000: dec.op = opSb;
                    // Branches comparing rs and rt or rs alone
                    6'b000100: dec.op = opBeq;
                    6'b000101: dec.op = opBne;
                    6'b000110: dec.op = opBlez;
                    6'b000111: dec.op = opBgtz;
                    6'b000010: begin
                        dec.op     = opJ;
                        dec.format = fmtJ;
                    end
                    6'b000011: begin
                        dec.op     = opJal;
                        dec.format = fmtJ;
                    end
                    default: dec.op = opNop;
                endcase
            end
        end
    end

endmodule

// ==== design/branchComparator.sv ====
// Resolves the branch condition of the decoded operation in the decode stage
`include "mipsDecode_params.svh"

module branchComparator import mipsDecodePkg::*; (
    input  opCode_e            op,
    input  logic [`DATA_W-1:0] rsData,
    input  logic [`DATA_W-1:0] rtData,
    output logic               taken
);

    logic rsNeg;
    logic rsZero;

    // Sign comes from the top bit only
    assign rsNeg  = rsData[`DATA_W-1];
    assign rsZero = (rsData == '0);

    always_comb begin
        case (op)
            opBeq:   taken = (rsData == rtData);
            opBne:   taken = (rsData != rtData);
            opBgez:  taken = !rsNeg;
            opBltz:  taken = rsNeg;
            opBgtz:  taken = !rsNeg && !rsZero;
            opBlez:  taken = rsNeg || rsZero;
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== design/registerFile.sv ====
// General register file with two combinational read ports, one write port and write-through
`include "mipsDecode_params.svh"

module registerFile import mipsDecodePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] raddrA,
    input  logic [`REG_ADDR_W-1:0] raddrB,
    output logic [`DATA_W-1:0]     rdataA,
    output logic [`DATA_W-1:0]     rdataB,
    input  regWrite_t              wb
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    // Zero register reads 0, a pending write is bypassed to the reader
    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb.en && (wb.addr == addr))
            return wb.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        rdataA = readPort(raddrA);
        rdataB = readPort(raddrB);
    end

endmodule

// ==== design/decodeStage.sv ====
// Decode stage: decoder, branch compare, destination select and the ID/EX pipeline register
`include "mipsDecode_params.svh"

module decodeStage import mipsDecodePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   clr,
    input  fetchBundle_t           fetch,
    output logic [`REG_ADDR_W-1:0] raddrA,
    output logic [`REG_ADDR_W-1:0] raddrB,
    input  logic [`DATA_W-1:0]     rdataA,
    input  logic [`DATA_W-1:0]     rdataB,
    output branchInfo_t            branch,
    output idExBundle_t            idEx
);

    decodedInstr_t          dec;
    logic                   taken;
    logic [`REG_ADDR_W-1:0] destReg;
    logic [`DATA_W-1:0]     destData;
    idExBundle_t            idExNext;

    instrDecoder u_decoder (
        .instr (fetch.instr),
        .dec   (dec)
    );

    branchComparator u_comparator (
        .op     (dec.op),
        .rsData (rdataA),
        .rtData (rdataB),
        .taken  (taken)
    );

    assign raddrA = dec.rs;
    assign raddrB = dec.rt;

    // Resolved in the same cycle for the next-PC logic
    assign branch = '{op: dec.op, taken: taken};

    always_comb begin
        if (dec.op == opJal)
            destReg = `REG_ADDR_W'(`LINK_REG);
        else if (dec.format == fmtR)
            destReg = dec.rd;
        else
            destReg = dec.rt;

        // Return address skips the delay slot
        if ((dec.op == opJal) || (dec.op == opJalr))
            destData = fetch.pc + `DATA_W'(8);
        else if (dec.op == opLui)
            destData = {dec.imm16, {(`DATA_W - 16){1'b0}}};
        else
            destData = '0;
    end

    assign idExNext = '{
        op:       dec.op,
        pc:       fetch.pc,
        rsData:   rdataA,
        rtData:   rdataB,
        imm16:    dec.imm16,
        shamt:    dec.shamt,
        destReg:  destReg,
        destData: destData
    };

    // Clear wins over stall, a cleared entry is a bubble
    always_ff @(posedge clk) begin
        if (rst || clr)
            idEx <= '0;
        else if (!stall)
            idEx <= idExNext;
    end

endmodule

// ==== design/mipsDecodeTop.sv ====
// Top level of the decode slice, connecting the register file to the decode stage
`include "mipsDecode_params.svh"

module mipsDecodeTop import mipsDecodePkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  logic         clr,
    input  fetchBundle_t fetch,
    input  regWrite_t    wb,
    output branchInfo_t  branch,
    output idExBundle_t  idEx
);

    logic [`REG_ADDR_W-1:0] raddrA;
    logic [`REG_ADDR_W-1:0] raddrB;
    logic [`DATA_W-1:0]     rdataA;
    logic [`DATA_W-1:0]     rdataB;

    registerFile u_regFile (
        .clk    (clk),
        .rst    (rst),
        .raddrA (raddrA),
        .raddrB (raddrB),
        .rdataA (rdataA),
        .rdataB (rdataB),
        .wb     (wb)
    );

    decodeStage u_decode (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .clr    (clr),
        .fetch  (fetch),
        .raddrA (raddrA),
        .raddrB (raddrB),
        .rdataA (rdataA),
        .rdataB (rdataB),
        .branch (branch),
        .idEx   (idEx)
    );

endmodule

// ==== verif/mipsDecode_asserts.sv ====
// Concurrent checks on the decode top level, bound into every mipsDecodeTop instance
`include "mipsDecode_params.svh"

module mipsDecodeAsserts import mipsDecodePkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               stall,
    input logic               clr,
    input fetchBundle_t       fetch,
    input regWrite_t          wb,
    input logic [`DATA_W-1:0] rdataA,
    input logic [`DATA_W-1:0] rdataB,
    input branchInfo_t        branch,
    input idExBundle_t        idEx
);
    timeunit 1ns;
    timeprecision 100ps;

    int errCount = 0;
    wire load = !rst && !clr && !stall;
    wire [4:0] rsF = fetch.instr[25:21];
    wire [4:0] rtF = fetch.instr[20:16];
    wire wbLive = wb.en && (wb.addr != '0);

    task automatic logFail(input string msg);
        errCount++;
        $error("Error %0t: %s", $time, msg);
    endtask

    // Supported SPECIAL functs, the all-zero word is a bubble
    function automatic logic rType(input logic [31:0] w);
        return (w != '0) && (w[31:26] == 6'd0) && (w[5:0] inside {[6'h20:6'h27], 6'h2a,
            6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09});
    endfunction

    // ALU immediates, loads, stores and the four opcode branches
    function automatic logic iType(input logic [31:0] w);
        return w[31:26] inside {[6'h04:6'h0f], 6'h20, 6'h21, 6'h23, 6'h24, 6'h25,
            6'h28, 6'h29, 6'h2b};
    endfunction

    function automatic logic knownWord(input logic [31:0] w);
        return rType(w) || iType(w) || (w[31:26] inside {6'h02, 6'h03})
            || ((w[31:26] == 6'h01) && (w[20:16] inside {5'd0, 5'd1}));
    endfunction

    // Sign judged by bit 31 only
    function automatic logic expectTaken(input logic [31:0] w, input logic [31:0] a, b);
        case (w[31:26])
            6'h04:   return a == b;
            6'h05:   return a != b;
            6'h06:   return a[31] || (a == '0);
            6'h07:   return !a[31] && (a != '0);
            6'h01:   return (w[20:16] == 5'd1) ? !a[31] : ((w[20:16] == 5'd0) && a[31]);
            default: return 1'b0;
        endcase
    endfunction

    assert property (@(posedge clk) $past(rst || clr) |-> idEx == '0)
        else logFail("idEx not cleared after reset or clear");
    assert property (@(posedge clk) $past(stall && !clr && !rst) |-> idEx == $past(idEx))
        else logFail("idEx changed during stall");
    assert property (@(posedge clk) $past(load) |-> idEx.pc == $past(fetch.pc))
        else logFail("idEx.pc does not follow fetch.pc");
    assert property (@(posedge clk) $past(load) |-> idEx.rsData == $past(rdataA)
        && idEx.rtData == $past(rdataB) && idEx.imm16 == $past(fetch.instr[15:0])
        && idEx.shamt == $past(fetch.instr[10:6])
        && (idEx.op == opNop) == !knownWord($past(fetch.instr)))
        else logFail("idEx fields do not follow the decoded word");
    assert property (@(posedge clk) $past(load && wbLive && wb.addr == rsF)
        |-> idEx.rsData == $past(wb.data))
        else logFail("write-through missing from idEx.rsData");
    assert property (@(posedge clk) $past(!rst && wbLive) && rtF == $past(wb.addr)
        && !(wb.en && wb.addr == rtF) |-> rdataB == $past(wb.data))
        else logFail("register read does not return the written data");
    assert property (@(posedge clk) (rsF != '0 || rdataA == '0) && (rtF != '0 || rdataB == '0))
        else logFail("register zero reads nonzero");
    assert property (@(posedge clk) branch.taken == expectTaken(fetch.instr, rdataA, rdataB))
        else logFail("branch.taken wrong");
    assert property (@(posedge clk) (branch.op == opNop) == !knownWord(fetch.instr))
        else logFail("opNop mismatch on branch.op");
    assert property (@(posedge clk) $past(load && fetch.instr[31:26] == 6'h03)
        |-> idEx.destReg == `REG_ADDR_W'(`LINK_REG) && idEx.destData == $past(fetch.pc) + 32'd8)
        else logFail("jal link register or return address wrong");
    assert property (@(posedge clk) $past(load && rType(fetch.instr) && fetch.instr[5:0] == 6'h09)
        |-> idEx.destData == $past(fetch.pc) + 32'd8)
        else logFail("jalr return address wrong");
    assert property (@(posedge clk) $past(load && fetch.instr[31:26] == 6'h0f)
        |-> idEx.destData == {$past(fetch.instr[15:0]), 16'd0})
        else logFail("lui upper immediate wrong");
    assert property (@(posedge clk) $past(load && rType(fetch.instr))
        |-> idEx.destReg == $past(fetch.instr[15:11]))
        else logFail("R-format destination is not rd");
    assert property (@(posedge clk) $past(load && iType(fetch.instr))
        |-> idEx.destReg == $past(fetch.instr[20:16]))
        else logFail("I-format destination is not rt");

endmodule

bind mipsDecodeTop mipsDecodeAsserts u_asserts (.*);

// ==== verif/mipsDecodeTb.sv ====
// Testbench for the decode top level, drives fetch and writeback while bound assertions check
`include "mipsDecode_params.svh"

module mipsDecodeTb import mipsDecodePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;

    logic               clk;
    logic               rst;
    logic               stall;
    logic               clr;
    fetchBundle_t       fetch;
    regWrite_t          wb;
    branchInfo_t        branch;
    idExBundle_t        idEx;
    logic [`DATA_W-1:0] pc;
    int                 cycles = 0;
    int                 errMark = 0;
    int                 passCount = 0;
    int                 failCount = 0;

    mipsDecodeTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] encodeR(input logic [4:0] rs, rt, rd, input logic [5:0] funct);
        return {6'd0, rs, rt, rd, 5'($urandom), funct};
    endfunction

    // Random immediate, also fills the jump target of j and jal
    function automatic logic [31:0] encodeI(input logic [5:0] opc, input logic [4:0] rs, rt);
        return {opc, rs, rt, 16'($urandom)};
    endfunction

    // Called at a falling edge, returns at the next one
    task automatic issue(input logic [31:0] word);
        fetch.instr = word;
        fetch.pc = pc;
        pc = pc + 32'd4;
        @(negedge clk);
    endtask

    task automatic finishTest(input string name);
        int errNow;
        repeat (2) @(negedge clk);
        errNow = u_dut.u_asserts.errCount;
        if (errNow == errMark) begin
            passCount++;
            $display("Test %s finished with no assertion failures", name);
        end else begin
            failCount++;
            $display("Test %s finished with %0d assertion failures", name, errNow - errMark);
        end
        errMark = errNow;
    endtask

    initial begin
        logic [`DATA_W-1:0] v;
        logic [`DATA_W-1:0] prev;
        logic [5:0] rFuncts [18] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
            6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09};
        logic [5:0] iOps [18] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b, 6'h02, 6'h03};
        void'($urandom(46));
        rst = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        fetch = '0;
        wb = '0;
        pc = 32'h0040_0000;
        prev = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        finishTest("reset");

        // Registers 2 and 3 equal, 4 negative, 5 positive, 6 zero
        for (int i = 1; i < `REG_COUNT; i++) begin
            v = (i == 3) ? prev : $urandom;
            if (i == 4)
                v[31] = 1'b1;
            if (i == 5)
                v[31] = 1'b0;
            if (i == 6)
                v = '0;
            prev = v;
            wb = '{en: 1'b1, addr: 5'(i), data: v};
            issue(encodeR(5'(i), 5'(i - 1), 5'($urandom), 6'h21));
        end
        // Write to register zero while reading it, neither bypassed nor stored
        wb = '{en: 1'b1, addr: 5'd0, data: 32'hffff_ffff};
        issue(encodeR(5'd0, 5'd0, 5'd1, 6'h21));
        wb.en = 1'b0;
        finishTest("register file");

        repeat (8) begin
            foreach (rFuncts[k])
                issue(encodeR(5'($urandom), 5'($urandom), 5'($urandom), rFuncts[k]));
            foreach (iOps[k])
                issue(encodeI(iOps[k], 5'($urandom), 5'($urandom)));
        end
        finishTest("decode and link");

        for (int r = 2; r < 7; r++) begin
            issue(encodeI(6'h04, 5'd2, 5'(r)));
            issue(encodeI(6'h05, 5'd2, 5'(r)));
            issue(encodeI(6'h06, 5'(r), 5'($urandom)));
            issue(encodeI(6'h07, 5'(r), 5'($urandom)));
            issue(encodeI(6'h01, 5'(r), 5'd0));
            issue(encodeI(6'h01, 5'(r), 5'd1));
        end
        finishTest("branch");

        issue('0);
        repeat (40)
            issue($urandom);
        finishTest("unknown encodings");

        stall = 1'b1;
        repeat (6)
            issue(encodeR(5'($urandom), 5'($urandom), 5'($urandom), 6'h20));
        // Clear together with stall, then alone
        clr = 1'b1;
        issue(encodeI(6'h03, 5'($urandom), 5'($urandom)));
        stall = 1'b0;
        issue(encodeI(6'h03, 5'($urandom), 5'($urandom)));
        clr = 1'b0;
        repeat (4)
            issue(encodeI(6'h03, 5'($urandom), 5'($urandom)));
        finishTest("stall and clear");

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== mipsDecode.f ====
+incdir+include
design/mipsDecodePkg.sv
design/instrDecoder.sv
design/branchComparator.sv
design/registerFile.sv
design/decodeStage.sv
design/mipsDecodeTop.sv
verif/mipsDecode_asserts.sv
verif/mipsDecodeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f mipsDecode.f \
    --top-module mipsDecodeTb -o mipsDecodeSim
./obj_dir/mipsDecodeSim +verilator+error+limit+1000 | tee sim.log
grep -q "=== PASS ===" sim.log
